/* common/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // ********************
  // widths and constants
  // ********************

  // data path and address width
  localparam int xlen = 32;
  // register index width
  localparam int reg_addr_w = 5;
  // number of general registers
  localparam int num_regs = 1 << reg_addr_w;
  // immediate field width
  localparam int imm_w = 16;
  // shift amount width, also the low rs bits used by variable shifts
  localparam int shamt_w = 5;
  // jal link destination
  localparam int link_reg = 31;
  // fetch address after reset
  localparam logic [xlen-1:0] reset_pc = '0;

  typedef logic [xlen-1:0] word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // ********************
  // instruction fields
  // ********************

  // primary opcode, instr[31:26]
  typedef enum logic [5:0] {
    op_special = 6'b000000,
    op_j       = 6'b000010,
    op_jal     = 6'b000011,
    op_beq     = 6'b000100,
    op_bne     = 6'b000101,
    op_addi    = 6'b001000,
    op_addiu   = 6'b001001,
    op_slti    = 6'b001010,
    op_sltiu   = 6'b001011,
    op_andi    = 6'b001100,
    op_ori     = 6'b001101,
    op_xori    = 6'b001110,
    op_lui     = 6'b001111,
    op_lw      = 6'b100011,
    op_sw      = 6'b101011
  } opcode_t;

  // function field of special opcode, instr[5:0]
  typedef enum logic [5:0] {
    fn_sll  = 6'b000000,
    fn_srl  = 6'b000010,
    fn_sra  = 6'b000011,
    fn_sllv = 6'b000100,
    fn_srlv = 6'b000110,
    fn_srav = 6'b000111,
    fn_jr   = 6'b001000,
    fn_add  = 6'b100000,
    fn_addu = 6'b100001,
    fn_sub  = 6'b100010,
    fn_subu = 6'b100011,
    fn_and  = 6'b100100,
    fn_or   = 6'b100101,
    fn_xor  = 6'b100110,
    fn_nor  = 6'b100111,
    fn_slt  = 6'b101010,
    fn_sltu = 6'b101011
  } funct_t;

  // ********************
  // control
  // ********************

  // alu operations, add first so a cleared ctrl means add
  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
    alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_t;

  // next fetch address source
  typedef enum logic [1:0] {
    pc_seq, pc_branch, pc_jump, pc_reg
  } pc_sel_t;

  // decoded control, all zero is a no-op
  typedef struct packed {
    alu_op_t alu_op;
    logic    shift_by_imm;
    logic    use_imm;
    logic    sign_ext;
    logic    reg_write;
    logic    dest_rt;
    logic    link;
    logic    mem_read;
    logic    mem_write;
    logic    branch_eq;
    logic    branch_ne;
    pc_sel_t pc_sel;
  } ctrl_t;

endpackage

`default_nettype wire

/* decode/instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder import cpu_pkg::*; (
  input  wire word_t instr,
  output ctrl_t      ctrl
);

  opcode_t opcode;
  funct_t  funct;

  // field split
  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[5:0]);

  always_comb begin
    // defaults give a no-op
    ctrl        = '0;
    ctrl.alu_op = alu_add;
    ctrl.pc_sel = pc_seq;

    case (opcode)
      // ********************
      // register format
      // ********************
      op_special: begin
        // rd destination unless funct says otherwise
        ctrl.reg_write = 1'b1;
        case (funct)
          fn_add, fn_addu: ctrl.alu_op = alu_add;
          fn_sub, fn_subu: ctrl.alu_op = alu_sub;
          fn_and:          ctrl.alu_op = alu_and;
          fn_or:           ctrl.alu_op = alu_or;
          fn_xor:          ctrl.alu_op = alu_xor;
          fn_nor:          ctrl.alu_op = alu_nor;
          fn_slt:          ctrl.alu_op = alu_slt;
          fn_sltu:         ctrl.alu_op = alu_sltu;
          // shamt shifts
          fn_sll: begin
            ctrl.alu_op       = alu_sll;
            ctrl.shift_by_imm = 1'b1;
          end
          fn_srl: begin
            ctrl.alu_op       = alu_srl;
            ctrl.shift_by_imm = 1'b1;
          end
          fn_sra: begin
            ctrl.alu_op       = alu_sra;
            ctrl.shift_by_imm = 1'b1;
          end
          // variable shifts, amount from rs
          fn_sllv: ctrl.alu_op = alu_sll;
          fn_srlv: ctrl.alu_op = alu_srl;
          fn_srav: ctrl.alu_op = alu_sra;
          // register jump, no write
          fn_jr: begin
            ctrl.reg_write = 1'b0;
            ctrl.pc_sel    = pc_reg;
          end
          // unknown funct drops back to no-op
          default: ctrl.reg_write = 1'b0;
        endcase
      end

      // ********************
      // immediate format
      // ********************
      op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori, op_xori, op_lui: begin
        ctrl.reg_write = 1'b1;
        ctrl.dest_rt   = 1'b1;
        ctrl.use_imm   = 1'b1;
        // logic ops zero extend, arithmetic and compares sign extend
        ctrl.sign_ext  = (opcode == op_addi) || (opcode == op_addiu) ||
                         (opcode == op_slti) || (opcode == op_sltiu);
        case (opcode)
          op_slti:  ctrl.alu_op = alu_slt;
          op_sltiu: ctrl.alu_op = alu_sltu;
          op_andi:  ctrl.alu_op = alu_and;
          op_ori:   ctrl.alu_op = alu_or;
          op_xori:  ctrl.alu_op = alu_xor;
          op_lui:   ctrl.alu_op = alu_lui;
          default:  ctrl.alu_op = alu_add;
        endcase
      end

      // word load and store, address is rs plus offset
      op_lw: begin
        ctrl.use_imm   = 1'b1;
        ctrl.sign_ext  = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.dest_rt   = 1'b1;
        ctrl.mem_read  = 1'b1;
      end
      op_sw: begin
        ctrl.use_imm   = 1'b1;
        ctrl.sign_ext  = 1'b1;
        ctrl.mem_write = 1'b1;
      end

      // ********************
      // control flow
      // ********************
      // compare through rs - rt
      op_beq: begin
        ctrl.alu_op    = alu_sub;
        ctrl.branch_eq = 1'b1;
        ctrl.pc_sel    = pc_branch;
      end
      op_bne: begin
        ctrl.alu_op    = alu_sub;
        ctrl.branch_ne = 1'b1;
        ctrl.pc_sel    = pc_branch;
      end
      op_j: ctrl.pc_sel = pc_jump;
      // jal writes pc + 4 into r31
      op_jal: begin
        ctrl.pc_sel    = pc_jump;
        ctrl.reg_write = 1'b1;
        ctrl.link      = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* execute/execute_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module execute_unit import cpu_pkg::*; (
  input  wire ctrl_t ctrl,
  input  wire word_t instr,
  input  wire word_t pc,
  input  wire word_t rs_data,
  input  wire word_t rt_data,
  input  wire word_t ram_out,
  output word_t      alu_result,
  output logic       zero,
  output word_t      wb_data,
  output reg_addr_t  wb_addr
);

  word_t                imm_ext;
  word_t                op_a;
  word_t                op_b;
  logic [shamt_w-1:0]   shamt;
  word_t                pc_plus4;
  reg_addr_t            rt_addr;
  reg_addr_t            rd_addr;

  // ********************
  // operand select
  // ********************

  // immediate extension
  assign imm_ext = ctrl.sign_ext ? {{(xlen-imm_w){instr[imm_w-1]}}, instr[imm_w-1:0]}
                                 : {{(xlen-imm_w){1'b0}}, instr[imm_w-1:0]};

  // first operand, shamt field for sll/srl/sra
  assign op_a = ctrl.shift_by_imm ? {{(xlen-shamt_w){1'b0}}, instr[10:6]} : rs_data;

  // second operand
  assign op_b = ctrl.use_imm ? imm_ext : rt_data;

  // shift amount, low bits only
  assign shamt = op_a[shamt_w-1:0];

  // ********************
  // alu
  // ********************

  always_comb begin
    case (ctrl.alu_op)
      alu_add:  alu_result = op_a + op_b;
      alu_sub:  alu_result = op_a - op_b;
      alu_and:  alu_result = op_a & op_b;
      alu_or:   alu_result = op_a | op_b;
      alu_xor:  alu_result = op_a ^ op_b;
      alu_nor:  alu_result = ~(op_a | op_b);
      // signed compare
      alu_slt:  alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      // unsigned compare, also sltiu after sign extension
      alu_sltu: alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
      // shifts act on the second operand
      alu_sll:  alu_result = op_b << shamt;
      alu_srl:  alu_result = op_b >> shamt;
      alu_sra:  alu_result = word_t'($signed(op_b) >>> shamt);
      // immediate into upper half
      alu_lui:  alu_result = {op_b[imm_w-1:0], {(xlen-imm_w){1'b0}}};
      default:  alu_result = '0;
    endcase
  end

  // branch compare flag
  assign zero = (alu_result == '0);

  // ********************
  // write back
  // ********************

  // link value
  assign pc_plus4 = pc + word_t'(4);

  // loads take memory data, jal takes the return address
  always_comb begin
    if (ctrl.mem_read) begin
      wb_data = ram_out;
    end else if (ctrl.link) begin
      wb_data = pc_plus4;
    end else begin
      wb_data = alu_result;
    end
  end

  // destination fields
  assign rt_addr = instr[20:16];
  assign rd_addr = instr[15:11];

  // r31 for jal, rt for immediate forms, rd otherwise
  always_comb begin
    if (ctrl.link) begin
      wb_addr = reg_addr_t'(link_reg);
    end else if (ctrl.dest_rt) begin
      wb_addr = rt_addr;
    end else begin
      wb_addr = rd_addr;
    end
  end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file import cpu_pkg::*; (
  input  wire logic      clk_in,
  input  wire logic      rst_n,
  input  wire logic      we,
  input  wire reg_addr_t raddr1,
  input  wire reg_addr_t raddr2,
  input  wire reg_addr_t waddr,
  input  wire word_t     wdata,
  output word_t          rdata1,
  output word_t          rdata2
);

  // general registers
  word_t regs [0:num_regs-1];

  // ********************
  // write port
  // ********************

  // sync clear of every register while in reset
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      // r0 never written
      regs[waddr] <= wdata;
    end
  end

  // ********************
  // read ports
  // ********************

  // async reads on both ports
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

/* source/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit import cpu_pkg::*; (
  input  wire logic  clk_in,
  input  wire logic  rst_n,
  input  wire ctrl_t ctrl,
  input  wire logic  zero,
  input  wire word_t rs_data,
  input  wire word_t instr,
  output word_t      pc
);

  word_t pc_plus4;
  word_t br_offset;
  word_t br_target;
  word_t jmp_target;
  logic  br_taken;
  word_t next_pc;

  // sequential address
  assign pc_plus4 = pc + word_t'(4);

  // word offset, sign extended and scaled by 4
  assign br_offset = {{(xlen-imm_w-2){instr[imm_w-1]}}, instr[imm_w-1:0], 2'b00};
  assign br_target = pc_plus4 + br_offset;

  // region bits from pc + 4, 26-bit word target
  assign jmp_target = {pc_plus4[31:28], instr[25:0], 2'b00};

  // beq on zero, bne on not zero
  assign br_taken = (ctrl.branch_eq && zero) || (ctrl.branch_ne && !zero);

  // ********************
  // next address
  // ********************

  always_comb begin
    case (ctrl.pc_sel)
      // untaken branch falls through
      pc_branch: next_pc = br_taken ? br_target : pc_plus4;
      pc_jump:   next_pc = jmp_target;
      // jr
      pc_reg:    next_pc = rs_data;
      default:   next_pc = pc_plus4;
    endcase
  end

  // pc register, one instruction per clock
  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      pc <= reset_pc;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

`default_nettype wire

/* source/cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; (
  input  wire logic  clk_in,
  input  wire logic  rst_n,
  // instruction word at pc
  input  wire word_t imem,
  // load data, answered in the same cycle
  input  wire word_t ram_out,
  output word_t      pc,
  output word_t      addr,
  output word_t      dmem_in,
  // data memory strobes
  output logic       cs,
  output logic       dm_r,
  output logic       dm_w
);

  ctrl_t     ctrl;
  word_t     rs_data;
  word_t     rt_data;
  word_t     alu_result;
  logic      zero;
  word_t     wb_data;
  reg_addr_t wb_addr;

  // ********************
  // decode and registers
  // ********************

  instr_decoder u_decoder (
    .instr (imem),
    .ctrl  (ctrl)
  );

  // rs and rt fields index the read ports
  reg_file u_reg_file (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .we     (ctrl.reg_write),
    .raddr1 (imem[25:21]),
    .raddr2 (imem[20:16]),
    .waddr  (wb_addr),
    .wdata  (wb_data),
    .rdata1 (rs_data),
    .rdata2 (rt_data)
  );

  // ********************
  // execute and fetch
  // ********************

  execute_unit u_execute (
    .ctrl       (ctrl),
    .instr      (imem),
    .pc         (pc),
    .rs_data    (rs_data),
    .rt_data    (rt_data),
    .ram_out    (ram_out),
    .alu_result (alu_result),
    .zero       (zero),
    .wb_data    (wb_data),
    .wb_addr    (wb_addr)
  );

  pc_unit u_pc_unit (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .ctrl    (ctrl),
    .zero    (zero),
    .rs_data (rs_data),
    .instr   (imem),
    .pc      (pc)
  );

  // memory side, address straight from the alu
  assign addr    = alu_result;
  assign dmem_in = rt_data;

  // strobes held low through reset
  assign dm_r = rst_n & ctrl.mem_read;
  assign dm_w = rst_n & ctrl.mem_write;
  assign cs   = rst_n & (ctrl.mem_read | ctrl.mem_write);

endmodule

`default_nettype wire

/* dv/cpu_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions import cpu_pkg::*; (
  input wire logic  clk_in,
  input wire logic  rst_n,
  input wire logic  cs,
  input wire logic  dm_r,
  input wire logic  dm_w,
  input wire word_t pc
);

  // ********************
  // memory strobes
  // ********************

  // one access kind per cycle
  rw_exclusive: assert property (@(posedge clk_in) !(dm_r && dm_w))
    else $error("dm_r and dm_w high in the same cycle");

  // chip select follows the two strobes
  cs_matches: assert property (@(posedge clk_in) cs == (dm_r || dm_w))
    else $error("cs differs from dm_r or dm_w");

  // quiet bus during reset
  quiet_in_reset: assert property (@(posedge clk_in) !rst_n |-> !(cs || dm_r || dm_w))
    else $error("memory strobe high while rst_n is low");

  // ********************
  // fetch
  // ********************

  pc_aligned: assert property (@(posedge clk_in) disable iff (!rst_n) pc[1:0] == 2'b00)
    else $error("pc is not word aligned");

endmodule

bind cpu cpu_assertions u_assertions (
  .clk_in (clk_in),
  .rst_n  (rst_n),
  .cs     (cs),
  .dm_r   (dm_r),
  .dm_w   (dm_w),
  .pc     (pc)
);

`default_nettype wire

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

  localparam int num_steps  = 400;
  localparam int max_cycles = 600;
  localparam int stim_delay = 1;
  // result categories
  localparam logic [2:0] t_reset  = 3'd0;
  localparam logic [2:0] t_fetch  = 3'd1;
  localparam logic [2:0] t_memory = 3'd2;
  localparam logic [2:0] t_link   = 3'd3;
  localparam logic [2:0] t_zero   = 3'd4;
  localparam logic [2:0] t_strobe = 3'd5;

  logic  clk_in;
  logic  rst_n;
  word_t imem;
  word_t ram_out;
  word_t pc;
  word_t addr;
  word_t dmem_in;
  logic  cs;
  logic  dm_r;
  logic  dm_w;

  // program, data memory, and the model's copies
  word_t prog   [0:255];
  word_t dmem   [0:255];
  word_t m_mem  [0:255];
  word_t m_regs [0:31];
  word_t m_pc;
  // model predictions for the current cycle
  logic      exp_dm_r;
  logic      exp_dm_w;
  word_t     exp_addr;
  word_t     exp_data;
  logic      m_was_jr;
  logic      m_was_lw;
  reg_addr_t m_lw_rt;
  // per test counts
  int    n_checks   [0:5];
  int    n_errors   [0:5];
  string test_names [0:5];

  funct_t alu_fn [0:15] = '{fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor,
                            fn_nor, fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra, fn_sllv,
                            fn_srlv, fn_srav};
  opcode_t imm_ops [0:7] = '{op_addi, op_addiu, op_slti, op_sltiu, op_andi, op_ori,
                             op_xori, op_lui};

  cpu u_dut (
    .clk_in  (clk_in),
    .rst_n   (rst_n),
    .imem    (imem),
    .ram_out (ram_out),
    .pc      (pc),
    .addr    (addr),
    .dmem_in (dmem_in),
    .cs      (cs),
    .dm_r    (dm_r),
    .dm_w    (dm_w)
  );

  // memory answers within the cycle
  assign ram_out = dmem[addr[9:2]];

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  // ********************
  // encoding helpers
  // ********************

  function automatic int unsigned pick(input int unsigned n);
    return $urandom % n;
  endfunction

  function automatic word_t enc_r(input funct_t fn, input reg_addr_t rs, input reg_addr_t rt,
                                  input reg_addr_t rd, input logic [4:0] sa);
    return {op_special, rs, rt, rd, sa, fn};
  endfunction

  function automatic word_t enc_i(input opcode_t op, input reg_addr_t rs, input reg_addr_t rt,
                                  input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t enc_j(input opcode_t op, input logic [25:0] target);
    return {op, target};
  endfunction

  // r31 left for jal only
  function automatic reg_addr_t dest_reg();
    return reg_addr_t'(pick(31));
  endfunction

  function automatic word_t rand_alu_r();
    return enc_r(alu_fn[4'(pick(16))], reg_addr_t'(pick(32)), reg_addr_t'(pick(32)),
                 dest_reg(), 5'(pick(32)));
  endfunction

  function automatic word_t rand_alu_i();
    return enc_i(imm_ops[3'(pick(8))], reg_addr_t'(pick(32)), dest_reg(),
                 16'(pick(65536)));
  endfunction

  // call blocks sit at slots 8..11 of each 16
  function automatic logic in_call(input int unsigned i);
    return (i < 240) && (i % 16 >= 8) && (i % 16 <= 11);
  endfunction

  // forward targets that skip the call bodies
  function automatic int unsigned fwd_target(input int unsigned i);
    int unsigned t;
    t = i + 1 + pick(8);
    if (t > 255 || (t < 240 && (t % 16 == 10 || t % 16 == 11))) begin
      t = i + 1;
    end
    return t;
  endfunction

  task automatic build_program();
    int unsigned i;
    int unsigned t;
    int unsigned kind;
    reg_addr_t   r;
    // lui/ori seeds for r1..r4
    for (i = 0; i < 4; i++) begin
      prog[8'(2*i)]   = enc_i(op_lui, 5'd0, 5'(i + 1), 16'(pick(65536)));
      prog[8'(2*i+1)] = enc_i(op_ori, 5'(i + 1), 5'(i + 1), 16'(pick(65536)));
    end
    // jal into a short body whose jr returns to a jump over it
    for (i = 8; i < 240; i += 16) begin
      prog[8'(i)]   = enc_j(op_jal, 26'(i + 2));
      prog[8'(i+1)] = enc_j(op_j, 26'(i + 4));
      prog[8'(i+2)] = rand_alu_r();
      prog[8'(i+3)] = enc_r(fn_jr, 5'd31, 5'd0, 5'd0, 5'd0);
    end
    prog[255] = enc_j(op_j, 26'd0);
    i = 8;
    while (i < 255) begin
      kind = pick(20);
      if (in_call(i)) begin
        i++;
      end else if (kind >= 15 && kind <= 16 && i + 1 < 255 && !in_call(i + 1)) begin
        // load then store of the same register
        r = dest_reg();
        prog[8'(i)]   = enc_i(op_lw, 5'd0, r, 16'(pick(256) * 4));
        prog[8'(i+1)] = enc_i(op_sw, 5'd0, r, 16'(pick(256) * 4));
        i += 2;
      end else begin
        if (kind <= 5) begin
          prog[8'(i)] = rand_alu_r();
        end else if (kind <= 10) begin
          prog[8'(i)] = rand_alu_i();
        end else if (kind <= 12 || (kind >= 15 && kind <= 16)) begin
          prog[8'(i)] = enc_i(op_lw, 5'd0, dest_reg(), 16'(pick(256) * 4));
        end else if (kind <= 14) begin
          prog[8'(i)] = enc_i(op_sw, 5'd0, reg_addr_t'(pick(32)), 16'(pick(256) * 4));
        end else if (kind <= 18) begin
          t = fwd_target(i);
          if (pick(2) == 0) begin
            prog[8'(i)] = enc_i(op_beq, reg_addr_t'(pick(32)), reg_addr_t'(pick(32)),
                                16'(t - i - 1));
          end else begin
            prog[8'(i)] = enc_i(op_bne, reg_addr_t'(pick(32)), reg_addr_t'(pick(32)),
                                16'(t - i - 1));
          end
        end else begin
          prog[8'(i)] = enc_j(op_j, 26'(fwd_target(i)));
        end
        i++;
      end
    end
    // write to r0 then store it right after the first call
    prog[12] = enc_i(op_addi, 5'd0, 5'd0, 16'h1234);
    prog[13] = enc_i(op_sw, 5'd0, 5'd0, 16'h0040);
  endtask

  // ********************
  // reference model
  // ********************

  task automatic model_step(input word_t ins);
    logic [5:0] op;
    logic [5:0] fn;
    reg_addr_t  rs;
    reg_addr_t  rt;
    logic [4:0] sa;
    word_t      a;
    word_t      b;
    word_t      simm;
    word_t      res;
    word_t      npc;
    reg_addr_t  dst;
    logic       wr;
    op   = ins[31:26];
    rs   = ins[25:21];
    rt   = ins[20:16];
    sa   = ins[10:6];
    fn   = ins[5:0];
    a    = m_regs[rs];
    b    = m_regs[rt];
    simm = {{16{ins[15]}}, ins[15:0]};
    res  = '0;
    npc  = m_pc + 32'd4;
    dst  = ins[15:11];
    wr   = 1'b0;
    exp_dm_r = 1'b0;
    exp_dm_w = 1'b0;
    exp_addr = '0;
    exp_data = '0;
    m_was_jr = 1'b0;
    m_was_lw = 1'b0;
    case (op)
      6'h00: begin
        wr = 1'b1;
        case (fn)
          6'h20, 6'h21: res = a + b;
          6'h22, 6'h23: res = a - b;
          6'h24: res = a & b;
          6'h25: res = a | b;
          6'h26: res = a ^ b;
          6'h27: res = ~(a | b);
          6'h2a: res = {31'd0, $signed(a) < $signed(b)};
          6'h2b: res = {31'd0, a < b};
          6'h00: res = b << sa;
          6'h02: res = b >> sa;
          6'h03: res = word_t'($signed(b) >>> sa);
          6'h04: res = b << a[4:0];
          6'h06: res = b >> a[4:0];
          6'h07: res = word_t'($signed(b) >>> a[4:0]);
          6'h08: begin
            wr       = 1'b0;
            npc      = a;
            m_was_jr = 1'b1;
          end
          default: wr = 1'b0;
        endcase
      end
      // immediate group where the low opcode bits pick the op
      6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
        wr  = 1'b1;
        dst = rt;
        case (op[2:0])
          3'd0, 3'd1: res = a + simm;
          3'd2: res = {31'd0, $signed(a) < $signed(simm)};
          3'd3: res = {31'd0, a < simm};
          3'd4: res = a & {16'h0000, ins[15:0]};
          3'd5: res = a | {16'h0000, ins[15:0]};
          3'd6: res = a ^ {16'h0000, ins[15:0]};
          3'd7: res = {ins[15:0], 16'h0000};
        endcase
      end
      6'h23: begin
        wr       = 1'b1;
        dst      = rt;
        exp_dm_r = 1'b1;
        exp_addr = a + simm;
        res      = m_mem[exp_addr[9:2]];
        m_was_lw = 1'b1;
        m_lw_rt  = rt;
      end
      6'h2b: begin
        exp_dm_w = 1'b1;
        exp_addr = a + simm;
        exp_data = b;
        m_mem[exp_addr[9:2]] = b;
      end
      6'h04: if (a == b) npc = npc + {simm[29:0], 2'b00};
      6'h05: if (a != b) npc = npc + {simm[29:0], 2'b00};
      6'h02: npc = {npc[31:28], ins[25:0], 2'b00};
      6'h03: begin
        wr  = 1'b1;
        dst = 5'd31;
        res = npc;
        npc = {npc[31:28], ins[25:0], 2'b00};
      end
      default: ;
    endcase
    if (wr && dst != 5'd0) begin
      m_regs[dst] = res;
    end
    m_pc = npc;
  endtask

  // ********************
  // checks
  // ********************

  task automatic check_word(input string name, input word_t exp, input word_t act,
                            input logic [2:0] cat);
    n_checks[cat] += 1;
    if (act !== exp) begin
      n_errors[cat] += 1;
      $display("CHECK FAILED %s: expected 0x%08h, actual 0x%08h (%s, %0t)",
               name, exp, act, test_names[cat], $time);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act,
                           input logic [2:0] cat);
    n_checks[cat] += 1;
    if (act !== exp) begin
      n_errors[cat] += 1;
      $display("CHECK FAILED %s: expected 0x%h, actual 0x%h (%s, %0t)",
               name, exp, act, test_names[cat], $time);
    end
  endtask

  task automatic report_test(input logic [2:0] cat);
    $display("test %s done: %0d checks, %0d errors", test_names[cat], n_checks[cat],
             n_errors[cat]);
  endtask

  // run limit
  initial begin
    int cyc;
    for (cyc = 0; cyc < max_cycles; cyc++) begin
      @(posedge clk_in);
    end
    $display("timeout: run did not finish within %0d clock cycles", max_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

  // ********************
  // main sequence
  // ********************

  initial begin
    int          k;
    int          tot_checks;
    int          tot_errors;
    word_t       ins;
    logic        prev_jr;
    logic        prev_lw;
    reg_addr_t   prev_lw_rt;
    logic        st_en;
    logic [7:0]  st_idx;
    word_t       st_data;
    void'($urandom(26));
    // sw word held in reset so the strobe gating is exercised
    rst_n = 1'b0;
    imem  = enc_i(op_sw, 5'd0, 5'd5, 16'h0010);
    test_names = '{"reset", "fetch", "memory", "loads_link", "reg_zero", "strobes"};
    for (k = 0; k < 6; k++) begin
      n_checks[3'(k)] = 0;
      n_errors[3'(k)] = 0;
    end
    // address dependent fill
    for (k = 0; k < 256; k++) begin
      dmem[8'(k)]  = (word_t'(k) * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
      m_mem[8'(k)] = (word_t'(k) * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
    end
    for (k = 0; k < 32; k++) begin
      m_regs[5'(k)] = '0;
    end
    m_pc     = reset_pc;
    m_was_jr = 1'b0;
    m_was_lw = 1'b0;
    m_lw_rt  = '0;
    build_program();

    for (k = 0; k < 8; k++) begin
      @(negedge clk_in);
      check_bit("cs", 1'b0, cs, t_reset);
      check_bit("dm_r", 1'b0, dm_r, t_reset);
      check_bit("dm_w", 1'b0, dm_w, t_reset);
    end
    @(posedge clk_in);
    #stim_delay;
    rst_n = 1'b1;
    imem  = prog[pc[9:2]];

    for (k = 0; k < num_steps; k++) begin
      @(negedge clk_in);
      if (k == 0) begin
        check_word("pc", reset_pc, pc, t_reset);
      end
      check_word("pc", m_pc, pc, t_fetch);
      // return address after jr r31
      if (m_was_jr) begin
        check_word("pc", m_pc, pc, t_link);
      end
      prev_lw    = m_was_lw;
      prev_lw_rt = m_lw_rt;
      ins        = prog[m_pc[9:2]];
      model_step(ins);
      check_bit("dm_r", exp_dm_r, dm_r, t_strobe);
      check_bit("dm_w", exp_dm_w, dm_w, t_strobe);
      check_bit("cs", exp_dm_r | exp_dm_w, cs, t_strobe);
      if (exp_dm_r || exp_dm_w) begin
        check_word("addr", exp_addr, addr, t_memory);
      end
      if (exp_dm_w) begin
        check_word("dmem_in", exp_data, dmem_in, t_memory);
        if (ins[20:16] == 5'd0) begin
          check_word("dmem_in", 32'd0, dmem_in, t_zero);
        end
        if (prev_lw && ins[20:16] == prev_lw_rt) begin
          check_word("dmem_in", exp_data, dmem_in, t_link);
        end
      end
      // store lands at the closing edge
      st_en   = dm_w;
      st_idx  = addr[9:2];
      st_data = dmem_in;
      @(posedge clk_in);
      if (st_en) begin
        dmem[st_idx] = st_data;
      end
      #stim_delay;
      imem = prog[pc[9:2]];
      if (k == 0) begin
        report_test(t_reset);
      end
    end

    for (k = 1; k < 6; k++) begin
      report_test(3'(k));
    end
    tot_checks = 0;
    tot_errors = 0;
    for (k = 0; k < 6; k++) begin
      tot_checks += n_checks[3'(k)];
      tot_errors += n_errors[3'(k)];
    end
    $display("totals: %0d checks, %0d errors", tot_checks, tot_errors);
    if (tot_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cpu.f */
common/cpu_pkg.sv
decode/instr_decoder.sv
execute/execute_unit.sv
source/reg_file.sv
source/pc_unit.sv
source/cpu.sv
dv/cpu_assertions.sv
dv/cpu_tb.sv

/* Makefile */
# Verilator build and run of the cpu testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= cpu.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= STATUS: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
